/* bench/tb_rf_downconv.sv */
`timescale 1ns/1ps
`include "rf_consts.svh"

module tb_rf_downconv;

	localparam longint MON_MAX = (64'sd1 <<< (`MON_W - 1)) - 1;
	localparam longint MON_MIN = -MON_MAX - 1;

	logic                     clk;
	logic                     ctlr_ph_reset;
	rf_pkg::adc_vec_t         adc_bus;
	logic [31:0]              phase_step;
	logic [11:0]              modulo;
	logic                     phase_resync;
	logic [7:0]               wave_samp_per;
	rf_pkg::mon_cfg_t         mon_cfg;
	rf_pkg::lo_t              lo;
	logic                     cic_sample;
	logic signed [`MON_W-1:0] mon_result;
	logic                     mon_strobe;
	logic                     mon_boundary;
	logic [6:0]               sat_count;

	// Full-scale ADC mode for the saturation phase
	bit                       full_scale;
	logic signed [`LO_W-1:0]  tbl [64];

	// Reference timer, DDS and mixer state
	int                       m_cnt;
	int                       m_wcnt;
	bit                       m_cic;
	bit                       m_req;
	bit                       m_dds;
	bit                       m_valid;
	bit                       m_wave_d;
	logic [11:0]              m_acc_l;
	logic [19:0]              m_acc_h = '0;
	logic [12:0]              m_sum_l;
	logic                     m_carry;
	logic [5:0]               m_idx;
	logic signed [`LO_W-1:0]  m_cos = '0;
	logic signed [`LO_W-1:0]  m_sin = '0;
	longint                   m_prod_i [`NCHAN];
	longint                   m_prod_q [`NCHAN];
	longint                   m_acc_i [`NCHAN];
	longint                   m_acc_q [`NCHAN];
	longint                   m_sum_i [`NCHAN];
	longint                   m_sum_q [`NCHAN];
	int                       m_sat;

	// Expected monitor stream, one entry per word
	longint                   q_word [$];
	bit                       q_bnd [$];
	int                       q_sat [$];
	int                       exp_sat;

	rf_downconv_top uut (
		.clk           (clk),
		.ctlr_ph_reset (ctlr_ph_reset),
		.adc           (adc_bus),
		.phase_step    (phase_step),
		.modulo        (modulo),
		.phase_resync  (phase_resync),
		.wave_samp_per (wave_samp_per),
		.mon_cfg       (mon_cfg),
		.lo            (lo),
		.cic_sample    (cic_sample),
		.mon_result    (mon_result),
		.mon_strobe    (mon_strobe),
		.mon_boundary  (mon_boundary),
		.sat_count     (sat_count)
	);

	always #50 clk = ~clk;

	task automatic stop_on_error();
		$display("Checks failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_val(input string name, input logic signed [63:0] got,
			input logic signed [63:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// Kept words of one captured frame, channel 0 I first
	task automatic push_frame();
		longint v;
		bit     first;
		first = 1'b1;
		for (int w = 0; w < 2 * `NCHAN; w++) begin
			if (mon_cfg.chan_keep[w]) begin
				v = (w % 2 == 0) ? m_sum_i[w / 2] : m_sum_q[w / 2];
				v = v >>> (`SHIFT_BASE + mon_cfg.wave_shift);
				// Clip to monitor width, counter sticks at 127
				if (v > MON_MAX || v < MON_MIN) begin
					v = (v > 0) ? MON_MAX : MON_MIN;
					if (m_sat < 127)
						m_sat++;
				end
				q_word.push_back(v);
				q_bnd.push_back(first);
				q_sat.push_back(m_sat);
				first = 1'b0;
			end
		end
	endtask

	// Cycle model, consumers first so every stage sees pre-edge values
	always @(posedge clk) begin
		if (ctlr_ph_reset) begin
			q_word.delete();
			q_bnd.delete();
			q_sat.delete();
			m_sat    = 0;
			m_wave_d = 1'b0;
		end else begin
			if (m_valid && m_wave_d)
				push_frame();
			m_wave_d = m_cic && (m_wcnt == 1);
		end
		// Integrate and dump
		for (int k = 0; k < `NCHAN; k++) begin
			if (m_cic) begin
				m_sum_i[k] = m_acc_i[k] + m_prod_i[k];
				m_sum_q[k] = m_acc_q[k] + m_prod_q[k];
			end
			if (ctlr_ph_reset || m_cic) begin
				m_acc_i[k] = 0;
				m_acc_q[k] = 0;
			end else begin
				m_acc_i[k] += m_prod_i[k];
				m_acc_q[k] += m_prod_q[k];
			end
			m_prod_i[k] = longint'($signed(adc_bus[k])) * longint'(m_cos);
			m_prod_q[k] = longint'($signed(adc_bus[k])) * longint'(m_sin);
		end
		m_valid = !ctlr_ph_reset && m_cic;
		// Lookup from the old phase, sine a quarter period back
		m_idx = m_acc_h[19:14];
		m_cos = tbl[m_idx];
		m_sin = tbl[m_idx - 6'd16];
		// Low part wraps at 4096 - modulo
		m_sum_l = {1'b0, m_acc_l} + {1'b0, phase_step[11:0]};
		m_carry = (m_sum_l >= 13'd4096 - {1'b0, modulo});
		if (ctlr_ph_reset || m_dds) begin
			m_acc_l = '0;
			m_acc_h = '0;
		end else begin
			m_acc_l = m_carry ? 12'(m_sum_l - (13'd4096 - {1'b0, modulo})) : m_sum_l[11:0];
			m_acc_h = m_acc_h + phase_step[31:12] + 20'(m_carry);
		end
		// Window tick, monitor divider, deferred resync
		if (ctlr_ph_reset) begin
			m_cnt  = 0;
			m_cic  = 1'b0;
			m_wcnt = 1;
			m_req  = 1'b0;
			m_dds  = 1'b0;
		end else begin
			m_dds = m_cic && m_req;
			if (m_cic) begin
				m_req  = 1'b0;
				m_wcnt = (m_wcnt != 1) ? m_wcnt - 1 :
					(wave_samp_per == 8'd0) ? 1 : int'(wave_samp_per);
			end
			if (phase_resync)
				m_req = 1'b1;
			m_cic = (m_cnt == 0);
			m_cnt = (m_cnt == `CIC_PERIOD - 1) ? 0 : m_cnt + 1;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (ctlr_ph_reset) begin
			exp_sat = 0;
		end else begin
			check_val("cic_sample", cic_sample, m_cic);
			check_val("lo.cos", lo.cos, m_cos);
			check_val("lo.sin", lo.sin, m_sin);
			if (mon_strobe && q_word.size() == 0) begin
				$display("Monitor word at %0t ns arrived with no frame expected", $time);
				stop_on_error();
			end else begin
				if (mon_strobe) begin
					check_val("mon_result", mon_result, q_word.pop_front());
					check_val("mon_boundary", mon_boundary, q_bnd.pop_front());
					exp_sat = q_sat.pop_front();
				end else begin
					check_val("mon_boundary", mon_boundary, 1'b0);
				end
				check_val("sat_count", sat_count, exp_sat);
			end
		end
	end

	// One clock with fresh ADC samples
	task automatic tick_clock();
		@(posedge clk);
		phase_resync <= 1'b0;
		for (int k = 0; k < `NCHAN; k++) begin
			if (full_scale)
				adc_bus[k] <= (k == 1) ? 16'h8000 : 16'h7fff;
			else
				adc_bus[k] <= 16'($urandom);
		end
	endtask

	task automatic pulse_resync();
		tick_clock();
		// Overrides the clear from tick_clock
		phase_resync <= 1'b1;
	endtask

	task automatic wait_drain();
		int guard;
		guard = 0;
		while (q_word.size() != 0) begin
			if (guard == 100) begin
				$display("Timeout: monitor frame still streaming after 100 cycles");
				stop_on_error();
			end
			tick_clock();
			guard++;
		end
	endtask

	// New config under reset, so the low phase restarts below its new wrap
	task automatic run_phase(input logic [7:0] per, input logic [5:0] keep,
			input logic [2:0] shift, input bit fs, input int ticks);
		logic [11:0] mod_v;
		logic [12:0] wrap;
		logic [31:0] step_v;
		int          len;
		int          at;
		mod_v  = 12'($urandom);
		wrap   = 13'd4096 - {1'b0, mod_v};
		step_v = fs ? 32'd0 : {20'($urandom), 12'($urandom % wrap)};
		len    = ticks * `CIC_PERIOD;
		at     = 20 + int'($urandom % (len - 40));
		full_scale = fs;
		ctlr_ph_reset        <= 1'b1;
		modulo               <= mod_v;
		phase_step           <= step_v;
		wave_samp_per        <= per;
		mon_cfg.chan_keep    <= keep;
		mon_cfg.wave_shift   <= shift;
		repeat (4) tick_clock();
		ctlr_ph_reset <= 1'b0;
		repeat (at) tick_clock();
		// Mid-window resync, lands on the next tick
		pulse_resync();
		repeat (len - at + 4) tick_clock();
		wait_drain();
	endtask

	initial begin
		clk           = 1'b0;
		ctlr_ph_reset = 1'b1;
		adc_bus       = '0;
		phase_step    = '0;
		modulo        = '0;
		phase_resync  = 1'b0;
		wave_samp_per = 8'd1;
		mon_cfg       = '0;
		full_scale    = 1'b0;
		exp_sat       = 0;
		void'($urandom(32'h6d1ab390));
		$readmemh("verilog/lo_table.hex", tbl);
		// Every tick, every word
		run_phase(8'd1, 6'h3f, 3'($urandom), 1'b0, 12);
		// Every third tick
		run_phase(8'd3, 6'($urandom), 3'($urandom), 1'b0, 14);
		// Period 0 behaves like 1, empty mask gives no frame
		run_phase(8'd0, 6'h00, 3'($urandom), 1'b0, 8);
		run_phase(8'd0, 6'h3f, 3'($urandom), 1'b0, 8);
		for (int p = 0; p < 4; p++)
			run_phase(8'($urandom % 5), 6'($urandom), 3'($urandom), 1'b0, 10);
		// Constant LO and full-scale input, 3 clipped words per frame
		run_phase(8'd1, 6'h3f, 3'd0, 1'b1, 50);
		@(negedge clk);
		check_val("sat_count", sat_count, 127);
		$display("All checks passed");
		$finish;
	end

endmodule

/* project.f */
+incdir+verilog
verilog/rf_pkg.sv
verilog/decim_timer.sv
verilog/lo_dds.sv
verilog/mixer_channel.sv
verilog/chan_serializer.sv
verilog/rf_downconv_top.sv
bench/tb_rf_downconv.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rf_downconv -f project.f -o tb_sim
out=$(./obj_dir/tb_sim || true)
echo "$out"
echo "$out" | grep -q "All checks passed"

/* verilog/chan_serializer.sv */
`timescale 1ns/1ps
`include "rf_consts.svh"

module chan_serializer (
	input  logic                                clk,
	input  logic                                ctlr_ph_reset,
	input  rf_pkg::iq_acc_t [`NCHAN-1:0]        sums,
	input  logic                                sum_valid,
	input  logic                                wave_sample,
	input  rf_pkg::mon_cfg_t                    mon_cfg,
	output logic signed [`MON_W-1:0]            mon_result,
	output logic                                mon_strobe,
	output logic                                mon_boundary,
	output logic [6:0]                          sat_count
);

	localparam int NWORD = 2 * `NCHAN;
	localparam int PTR_W = $clog2(NWORD);

	// wave_sample lined up with sum_valid
	logic wave_d;
	logic capture;

	// Captured frame, word 2k is channel k I, 2k+1 its Q
	logic signed [`ACC_W-1:0] frame [NWORD];
	logic [2:0]               shift_r;
	// Kept words not yet sent
	logic [NWORD-1:0]         pend;
	logic                     first;

	logic                     emit;
	logic [PTR_W-1:0]         ptr;
	logic signed [`ACC_W-1:0] scaled;
	logic [`ACC_W-`MON_W:0]   hi_bits;
	logic                     sat;
	logic [`MON_W-1:0]        sat_word;

	assign capture = sum_valid && wave_d;
	assign emit    = |pend;

	// Lowest pending word goes next
	always_comb begin
		ptr = '0;
		for (int w = NWORD - 1; w >= 0; w--) begin
			if (pend[w])
				ptr = PTR_W'(w);
		end
	end

	// Scale, then clip to the monitor width
	assign scaled   = frame[ptr] >>> (`SHIFT_BASE + shift_r);
	assign hi_bits  = scaled[`ACC_W-1:`MON_W-1];
	assign sat      = !((&hi_bits) || !(|hi_bits));
	assign sat_word = {scaled[`ACC_W-1], {(`MON_W - 1){~scaled[`ACC_W-1]}}};

	// Frame payload and output word
	always_ff @(posedge clk) begin
		if (capture) begin
			for (int k = 0; k < `NCHAN; k++) begin
				frame[2*k]     <= sums[k].i;
				frame[2*k + 1] <= sums[k].q;
			end
			shift_r <= mon_cfg.wave_shift;
		end
		if (emit)
			mon_result <= sat ? sat_word : scaled[`MON_W-1:0];
	end

	// Stream control and saturation count
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			wave_d       <= 1'b0;
			pend         <= '0;
			first        <= 1'b0;
			mon_strobe   <= 1'b0;
			mon_boundary <= 1'b0;
			sat_count    <= 7'd0;
		end else begin
			wave_d       <= wave_sample;
			mon_strobe   <= emit;
			mon_boundary <= emit && first;
			if (capture) begin
				// All-zero mask gives an empty frame
				pend  <= mon_cfg.chan_keep;
				first <= 1'b1;
			end else if (emit) begin
				pend[ptr] <= 1'b0;
				first     <= 1'b0;
			end
			// Sticks at full scale
			if (emit && sat && sat_count != 7'd127)
				sat_count <= sat_count + 7'd1;
		end
	end

	// Frame must drain well inside one decimation window
	a_no_overlap: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
		capture |-> (pend == '0));

endmodule

/* verilog/decim_timer.sv */
`timescale 1ns/1ps
`include "rf_consts.svh"

module decim_timer (
	input  logic       clk,
	input  logic       ctlr_ph_reset,
	input  logic [7:0] wave_samp_per,
	input  logic       phase_resync,
	output logic       cic_sample,
	output logic       wave_sample,
	output logic       dds_reset
);

	// Position inside the decimation window
	logic [5:0] cic_count;
	// Ticks left until the next monitored window
	logic [7:0] wave_cnt;
	logic [7:0] wave_reload;
	// Host asked for a phase restart, waiting for a tick
	logic       resync_req;

	// Period 0 acts like period 1, every tick
	assign wave_reload = (wave_samp_per == 8'd0) ? 8'd1 : wave_samp_per;

	// Window counter and tick
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			cic_count  <= 6'd0;
			cic_sample <= 1'b0;
		end else begin
			cic_count  <= (cic_count == 6'(`CIC_PERIOD - 1)) ? 6'd0 : cic_count + 6'd1;
			cic_sample <= (cic_count == 6'd0);
		end
	end

	// Waveform divider, steps only on ticks
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			wave_cnt <= 8'd1;
		end else if (cic_sample) begin
			wave_cnt <= (wave_cnt == 8'd1) ? wave_reload : wave_cnt - 8'd1;
		end
	end

	assign wave_sample = cic_sample && (wave_cnt == 8'd1);

	// Deferred resync, fires on the tick after the request
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			resync_req <= 1'b0;
			dds_reset  <= 1'b0;
		end else begin
			dds_reset <= cic_sample && resync_req;
			if (cic_sample)
				resync_req <= 1'b0;
			// New strobe on a tick waits for the next one
			if (phase_resync)
				resync_req <= 1'b1;
		end
	end

	// LO restart lands two clocks into the window, right behind the tick
	a_dds_reset_on_tick: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
		dds_reset |-> (cic_count == 6'd2));

endmodule

/* verilog/lo_dds.sv */
`timescale 1ns/1ps
`include "rf_consts.svh"

module lo_dds (
	input  logic         clk,
	input  logic         ctlr_ph_reset,
	input  logic         dds_reset,
	input  logic [31:0]  phase_step,
	input  logic [11:0]  modulo,
	output rf_pkg::lo_t  lo
);

	localparam int TBL_N = 1 << `TBL_BITS;
	// Quarter period offset turns cosine into sine
	localparam logic [`TBL_BITS-1:0] QUARTER = `TBL_BITS'(TBL_N / 4);

	// Phase step halves
	logic [11:0] step_l;
	logic [19:0] step_h;

	// Phase accumulator, low part wraps at 4096 - modulo
	logic [11:0] acc_l;
	logic [19:0] acc_h;

	// Low part arithmetic, one extra bit for the carry
	logic [12:0] wrap;
	logic [12:0] sum_l;
	logic        carry;
	logic [11:0] next_l;

	// Table addresses
	logic [`TBL_BITS-1:0] cos_idx;
	logic [`TBL_BITS-1:0] sin_idx;

	// One period of cosine
	logic signed [`LO_W-1:0] lo_tbl [TBL_N];

	initial begin
		$readmemh("verilog/lo_table.hex", lo_tbl);
	end

	assign step_l = phase_step[11:0];
	assign step_h = phase_step[31:12];

	// Non-power-of-two wrap gives exact fractional IF
	assign wrap   = 13'd4096 - {1'b0, modulo};
	assign sum_l  = {1'b0, acc_l} + {1'b0, step_l};
	assign carry  = (sum_l >= wrap);
	assign next_l = carry ? 12'(sum_l - wrap) : sum_l[11:0];

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset || dds_reset) begin
			acc_l <= 12'd0;
			acc_h <= 20'd0;
		end else begin
			acc_l <= next_l;
			acc_h <= acc_h + step_h + {19'd0, carry};
		end
	end

	// Top bits of the high part address the table
	assign cos_idx = acc_h[19 -: `TBL_BITS];
	// Index wraps modulo the table size
	assign sin_idx = cos_idx - QUARTER;

	// Registered lookup, one cycle behind the accumulator
	always_ff @(posedge clk) begin
		lo.cos <= lo_tbl[cos_idx];
		lo.sin <= lo_tbl[sin_idx];
	end

	// Low part stays under the wrap it was computed against
	a_low_below_wrap: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
		{1'b0, acc_l} < $past(wrap));

endmodule

/* verilog/lo_table.hex */
// 18-bit two's complement cosine, one sample per line, addresses 0 to 63
1FFFF
1FD88
1F629
1E9F3
1D906
1C38A
1A9B6
18BC7
16A09
144CF
11C73
0F15A
0C3EF
094A0
063E3
0322F
00000
3CDD1
39C1D
36B60
33C11
30EA6
2E38D
2BB31
295F7
27439
2564A
23C76
226FA
2160D
209D7
20278
20001
20278
209D7
2160D
226FA
23C76
2564A
27439
295F7
2BB31
2E38D
30EA6
33C11
36B60
39C1D
3CDD1
00000
0322F
063E3
094A0
0C3EF
0F15A
11C73
144CF
16A09
18BC7
1A9B6
1C38A
1D906
1E9F3
1F629
1FD88

/* verilog/mixer_channel.sv */
`timescale 1ns/1ps
`include "rf_consts.svh"

module mixer_channel (
	input  logic                     clk,
	input  logic                     ctlr_ph_reset,
	input  logic signed [`ADC_W-1:0] adc,
	input  rf_pkg::lo_t              lo,
	input  logic                     cic_sample,
	output rf_pkg::iq_acc_t          sum,
	output logic                     sum_valid
);

	localparam int PROD_W = `ADC_W + `LO_W;

	// Registered mixer products
	logic signed [PROD_W-1:0] prod_i;
	logic signed [PROD_W-1:0] prod_q;

	// Running integrals over the current window
	logic signed [`ACC_W-1:0] acc_i;
	logic signed [`ACC_W-1:0] acc_q;

	// I/Q demodulation against the shared LO
	always_ff @(posedge clk) begin
		prod_i <= adc * lo.cos;
		prod_q <= adc * lo.sin;
	end

	// Integrate and dump
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			acc_i <= '0;
			acc_q <= '0;
		end else if (cic_sample) begin
			// Last product of the window goes into the dump
			acc_i <= '0;
			acc_q <= '0;
		end else begin
			acc_i <= acc_i + prod_i;
			acc_q <= acc_q + prod_q;
		end
	end

	// Window result, held until the next tick
	always_ff @(posedge clk) begin
		if (cic_sample) begin
			sum.i <= acc_i + prod_i;
			sum.q <= acc_q + prod_q;
		end
	end

	// Marks the cycle the fresh sum is visible
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset)
			sum_valid <= 1'b0;
		else
			sum_valid <= cic_sample;
	end

	// Ticks from the timer are isolated, so dumps never run back to back
	a_valid_single: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
		sum_valid |=> !sum_valid);

endmodule

/* verilog/rf_consts.svh */
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// Number of ADC inputs, one mixer channel each
`define NCHAN 3

// Raw ADC sample width
`define ADC_W 16

// LO cosine and sine width
`define LO_W 18

// Integrate-and-dump accumulator width
`define ACC_W 40

// Waveform monitor word width
`define MON_W 20

// Clocks per decimation window, IF = clk * 7/33
`define CIC_PERIOD 33

// LO table address width, 64 entries per period
`define TBL_BITS 6

// Fixed right shift before the wave_shift adjustment
`define SHIFT_BASE 16

`endif

/* verilog/rf_downconv_top.sv */
`timescale 1ns/1ps
`include "rf_consts.svh"

module rf_downconv_top (
	input  logic                      clk,
	input  logic                      ctlr_ph_reset,
	input  rf_pkg::adc_vec_t          adc,
	input  logic [31:0]               phase_step,
	input  logic [11:0]               modulo,
	input  logic                      phase_resync,
	input  logic [7:0]                wave_samp_per,
	input  rf_pkg::mon_cfg_t          mon_cfg,
	output rf_pkg::lo_t               lo,
	output logic                      cic_sample,
	output logic signed [`MON_W-1:0]  mon_result,
	output logic                      mon_strobe,
	output logic                      mon_boundary,
	output logic [6:0]                sat_count
);

	logic wave_sample;
	logic dds_reset;

	// Per-channel window sums and their valid flags
	rf_pkg::iq_acc_t [`NCHAN-1:0] chan_sum;
	logic [`NCHAN-1:0]            chan_valid;

	// Window ticks, monitor divider, deferred resync
	decim_timer u_timer (
		.clk           (clk),
		.ctlr_ph_reset (ctlr_ph_reset),
		.wave_samp_per (wave_samp_per),
		.phase_resync  (phase_resync),
		.cic_sample    (cic_sample),
		.wave_sample   (wave_sample),
		.dds_reset     (dds_reset)
	);

	// Shared LO for all channels
	lo_dds u_dds (
		.clk           (clk),
		.ctlr_ph_reset (ctlr_ph_reset),
		.dds_reset     (dds_reset),
		.phase_step    (phase_step),
		.modulo        (modulo),
		.lo            (lo)
	);

	// One mixer per ADC input
	for (genvar k = 0; k < `NCHAN; k++) begin : g_chan
		mixer_channel u_mix (
			.clk           (clk),
			.ctlr_ph_reset (ctlr_ph_reset),
			.adc           (adc[k]),
			.lo            (lo),
			.cic_sample    (cic_sample),
			.sum           (chan_sum[k]),
			.sum_valid     (chan_valid[k])
		);
	end

	// Channels run in lockstep, channel 0 flag stands for all
	chan_serializer u_ser (
		.clk           (clk),
		.ctlr_ph_reset (ctlr_ph_reset),
		.sums          (chan_sum),
		.sum_valid     (chan_valid[0]),
		.wave_sample   (wave_sample),
		.mon_cfg       (mon_cfg),
		.mon_result    (mon_result),
		.mon_strobe    (mon_strobe),
		.mon_boundary  (mon_boundary),
		.sat_count     (sat_count)
	);

endmodule

/* verilog/rf_pkg.sv */
`include "rf_consts.svh"

package rf_pkg;

	// Local oscillator pair from the DDS
	typedef struct packed {
		logic signed [`LO_W-1:0] cos;
		logic signed [`LO_W-1:0] sin;
	} lo_t;

	// One window's I and Q integrals
	typedef struct packed {
		logic signed [`ACC_W-1:0] i;
		logic signed [`ACC_W-1:0] q;
	} iq_acc_t;

	// All ADC inputs side by side, channel k at index k
	typedef logic signed [`NCHAN-1:0][`ADC_W-1:0] adc_vec_t;

	// Waveform monitor setup from the host
	typedef struct packed {
		// Extra right shift on top of the base shift
		logic [2:0]          wave_shift;
		// Bit 2k keeps channel k I, bit 2k+1 keeps its Q
		logic [2*`NCHAN-1:0] chan_keep;
	} mon_cfg_t;

endpackage
